// ==== src/core_cfg.svh ====
// Core configuration defines
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ----------------------------------------------------------------------
// Widths
// ----------------------------------------------------------------------
`define CORE_XLEN    32          // Data word and PC width
`define CORE_NREGS   32          // x0..x31
`define CORE_REG_AW  5           // Register index width

// PC increment per accepted instruction
`define CORE_PC_STEP 4

// ----------------------------------------------------------------------
// Opcodes, bits [6:0] of the instruction word
// ----------------------------------------------------------------------
`define CORE_OP_REG   7'b0110011 // Register-register ALU ops
`define CORE_OP_IMM   7'b0010011 // Register-immediate ALU ops
`define CORE_OP_LUI   7'b0110111 // Load upper immediate
`define CORE_OP_AUIPC 7'b0010111 // Add upper immediate to PC

`endif

// ==== src/core_pkg.sv ====
// Core shared types
`include "core_cfg.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]   data_t;     // One data word
  typedef logic [`CORE_REG_AW-1:0] reg_addr_t; // Register index

  // ----------------------------------------------------------------------
  // Instruction word views
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;  // Sign extended in decode
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;  // Upper 20 bits of the result
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // Same 32-bit word, read through whichever view the opcode needs
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } instr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B           // LUI, result is operand B
  } alu_op_t;

  // Pending forward requests, one pair per source operand
  typedef struct packed {
    logic rs1_is;        // Take bus data in issue
    logic rs1_ex;        // Take bus data in execute
    logic rs2_is;
    logic rs2_ex;
  } fwd_sel_t;

  // ----------------------------------------------------------------------
  // Pipeline registers
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic      valid;
    data_t     pc;
    reg_addr_t rd;
    logic      we;         // Set only for a real write to rd != 0
    alu_op_t   alu_op;
    data_t     rs1_data;
    data_t     rs2_data;
    data_t     imm;
    logic      a_sel_pc;   // Operand A is the PC
    logic      b_sel_imm;  // Operand B is the immediate
    fwd_sel_t  fwd;
  } id_is_t;

  typedef struct packed {
    logic      valid;
    data_t     pc;
    reg_addr_t rd;
    logic      we;
    alu_op_t   alu_op;
    data_t     a_data;
    data_t     b_data;
    fwd_sel_t  fwd;        // Only the execute bits remain set
  } is_ex_t;

endpackage

// ==== src/core_ifs.sv ====
// Writeback bus interface

interface wb_bus_if import core_pkg::*; ();

  logic      valid;  // One strobe per retiring write
  reg_addr_t rd;     // Destination, never x0 while valid
  data_t     data;   // Result, also the forwarding source
  data_t     pc;     // PC of the retiring instruction

  // Execute stage drives the bus
  modport source (
    output valid,
    output rd,
    output data,
    output pc
  );

  // Decode, issue and register file listen
  modport sink (
    input valid,
    input rd,
    input data,
    input pc
  );

endinterface

// ==== src/fetch_unit.sv ====
// Instruction capture and PC
`include "core_cfg.svh"

module fetch_unit import core_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   ins_valid,  // Single-cycle strobe
  input  instr_t ins_data,
  output logic   if_valid,
  output instr_t if_instr,
  output data_t  if_pc
);

  data_t pc;  // PC of the next accepted instruction

  // ----------------------------------------------------------------------
  // PC counter, moves only on accepted instructions
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (ins_valid) begin
      pc <= pc + data_t'(`CORE_PC_STEP);
    end
  end

  // ----------------------------------------------------------------------
  // IF/ID register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if_instr <= ins_data;     // Payload, don't care on a bubble
    if_pc    <= pc;
    if (reset) begin
      if_valid <= 1'b0;
    end else begin
      if_valid <= ins_valid;  // Idle cycle becomes a bubble
    end
  end

endmodule

// ==== src/register_file.sv ====
// Integer register file
`include "core_cfg.svh"

module register_file import core_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output data_t     rs1_data,
  output data_t     rs2_data,
  wb_bus_if.sink    wb
);

  data_t regs [`CORE_NREGS];  // Entry 0 is never read

  // Write at the edge that closes the writeback cycle
  always_ff @(posedge clk) begin
    if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Asynchronous reads, x0 hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // ----------------------------------------------------------------------
  // Checks on the writeback bus
  // ----------------------------------------------------------------------
  // Decode and execute together must keep x0 writes off the bus
  a_no_x0_write : assert property (@(posedge clk) disable iff (reset)
    wb.valid |-> (wb.rd != '0));

  a_rd_known : assert property (@(posedge clk) disable iff (reset)
    wb.valid |-> !$isunknown(wb.rd));

endmodule

// ==== src/decode_stage.sv ====
// Instruction decode stage
`include "core_cfg.svh"

module decode_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      if_valid,
  input  instr_t    if_instr,
  input  data_t     if_pc,
  wb_bus_if.sink    wb,
  output id_is_t    id_is,
  input  reg_addr_t is_ex_rd,   // Destination held in IS/EX
  input  logic      is_ex_we    // IS/EX holds a real writer
);

  data_t    rf_rs1_data;
  data_t    rf_rs2_data;
  data_t    rs1_data;           // After writeback bypass
  data_t    rs2_data;
  logic     is_reg;
  logic     is_imm;
  logic     is_lui;
  logic     is_auipc;
  logic     rs1_used;
  logic     rs2_used;
  logic     we;
  alu_op_t  alu_op;
  data_t    imm;
  logic     rs1_hit_id_is;      // Producer one ahead, in issue
  logic     rs1_hit_is_ex;      // Two ahead, in execute
  logic     rs1_hit_ex_wb;      // Three ahead, on the bus
  logic     rs2_hit_id_is;
  logic     rs2_hit_is_ex;
  logic     rs2_hit_ex_wb;
  fwd_sel_t fwd;

  register_file i_regs (
    .clk      (clk),
    .reset    (reset),
    .rs1      (if_instr.r.rs1),
    .rs2      (if_instr.r.rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .wb       (wb)
  );

  // ----------------------------------------------------------------------
  // Opcode class and control
  // ----------------------------------------------------------------------
  assign is_reg   = (if_instr.r.opcode == `CORE_OP_REG);
  assign is_imm   = (if_instr.r.opcode == `CORE_OP_IMM);
  assign is_lui   = (if_instr.u.opcode == `CORE_OP_LUI);
  assign is_auipc = (if_instr.u.opcode == `CORE_OP_AUIPC);

  assign rs1_used = if_valid && (is_reg || is_imm);  // LUI/AUIPC have no rs1
  assign rs2_used = if_valid && is_reg;
  // Unknown opcode or rd = x0 never writes back
  assign we = if_valid && (is_reg || is_imm || is_lui || is_auipc) &&
              (if_instr.r.rd != '0);

  always_comb begin
    case (if_instr.r.funct3)
      3'b000:  alu_op = (is_reg && if_instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = if_instr.r.funct7[5] ? ALU_SRA : ALU_SRL;  // SRAI too
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
    if (is_lui) alu_op = ALU_PASS_B;
    if (is_auipc) alu_op = ALU_ADD;  // PC + upper immediate
  end

  // Immediate generator
  always_comb begin
    if (is_imm) begin
      imm = {{(`CORE_XLEN-12){if_instr.i.imm12[11]}}, if_instr.i.imm12};
    end else if (is_lui || is_auipc) begin
      imm = {if_instr.u.imm20, 12'b0};
    end else begin
      imm = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Forward compare, youngest producer first
  // ----------------------------------------------------------------------
  // Writers never carry rd = x0, so no zero check needed here
  function automatic logic hit(input logic used, input logic wr,
                               input reg_addr_t rd, input reg_addr_t rs);
    return used && wr && (rd == rs);
  endfunction

  assign rs1_hit_id_is = hit(rs1_used, id_is.we, id_is.rd, if_instr.r.rs1);
  assign rs1_hit_is_ex = hit(rs1_used, is_ex_we, is_ex_rd, if_instr.r.rs1);
  assign rs1_hit_ex_wb = hit(rs1_used, wb.valid, wb.rd, if_instr.r.rs1);
  assign rs2_hit_id_is = hit(rs2_used, id_is.we, id_is.rd, if_instr.r.rs2);
  assign rs2_hit_is_ex = hit(rs2_used, is_ex_we, is_ex_rd, if_instr.r.rs2);
  assign rs2_hit_ex_wb = hit(rs2_used, wb.valid, wb.rd, if_instr.r.rs2);

  assign fwd.rs1_ex = rs1_hit_id_is;
  assign fwd.rs1_is = !rs1_hit_id_is && rs1_hit_is_ex;
  assign fwd.rs2_ex = rs2_hit_id_is;
  assign fwd.rs2_is = !rs2_hit_id_is && rs2_hit_is_ex;

  // Bus value bypasses the write still pending in the register file
  assign rs1_data = (!rs1_hit_id_is && !rs1_hit_is_ex && rs1_hit_ex_wb) ?
                    wb.data : rf_rs1_data;
  assign rs2_data = (!rs2_hit_id_is && !rs2_hit_is_ex && rs2_hit_ex_wb) ?
                    wb.data : rf_rs2_data;

  // ----------------------------------------------------------------------
  // ID/IS register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    id_is.pc        <= if_pc;
    id_is.rd        <= if_instr.r.rd;
    id_is.alu_op    <= alu_op;
    id_is.rs1_data  <= rs1_data;
    id_is.rs2_data  <= rs2_data;
    id_is.imm       <= imm;
    id_is.a_sel_pc  <= is_auipc;
    id_is.b_sel_imm <= !is_reg;
    if (reset) begin
      id_is.valid <= 1'b0;
      id_is.we    <= 1'b0;
      id_is.fwd   <= '0;
    end else begin
      id_is.valid <= if_valid;
      id_is.we    <= we;
      id_is.fwd   <= fwd;
    end
  end

  // An operand is fed by exactly one stage downstream
  a_one_fwd : assert property (@(posedge clk) disable iff (reset)
    !(id_is.fwd.rs1_is && id_is.fwd.rs1_ex) &&
    !(id_is.fwd.rs2_is && id_is.fwd.rs2_ex));

endmodule

// ==== src/issue_stage.sv ====
// Instruction issue stage

module issue_stage import core_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  id_is_t id_is,
  wb_bus_if.sink wb,
  output is_ex_t is_ex
);

  data_t    rs1_val;   // Register operands after issue forwarding
  data_t    rs2_val;
  data_t    a_data;
  data_t    b_data;
  fwd_sel_t fwd_left;  // Forward bits still owed to execute

  // ----------------------------------------------------------------------
  // Issue forward, register operands only
  // ----------------------------------------------------------------------
  assign rs1_val = id_is.fwd.rs1_is ? wb.data : id_is.rs1_data;  // Producer on bus now
  assign rs2_val = id_is.fwd.rs2_is ? wb.data : id_is.rs2_data;

  // Operand select after forwarding, PC and immediate are never forwarded
  assign a_data = id_is.a_sel_pc  ? id_is.pc  : rs1_val;
  assign b_data = id_is.b_sel_imm ? id_is.imm : rs2_val;

  // Issue bits consumed here
  assign fwd_left = '{
    rs1_is: 1'b0,
    rs1_ex: id_is.fwd.rs1_ex,
    rs2_is: 1'b0,
    rs2_ex: id_is.fwd.rs2_ex
  };

  // ----------------------------------------------------------------------
  // IS/EX register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    is_ex.pc     <= id_is.pc;
    is_ex.rd     <= id_is.rd;
    is_ex.alu_op <= id_is.alu_op;
    is_ex.a_data <= a_data;
    is_ex.b_data <= b_data;
    if (reset) begin
      is_ex.valid <= 1'b0;
      is_ex.we    <= 1'b0;
      is_ex.fwd   <= '0;
    end else begin
      is_ex.valid <= id_is.valid;
      is_ex.we    <= id_is.we;
      is_ex.fwd   <= fwd_left;
    end
  end

endmodule

// ==== src/execute_stage.sv ====
// Integer execute stage
`include "core_cfg.svh"

module execute_stage import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  is_ex_t   is_ex,
  wb_bus_if.source wb
);

  localparam int unsigned shamt_w = $clog2(`CORE_XLEN);

  data_t              op_a;
  data_t              op_b;
  data_t              result;
  logic [shamt_w-1:0] shamt;

  // ----------------------------------------------------------------------
  // Execute forward from the instruction retiring this cycle
  // ----------------------------------------------------------------------
  assign op_a  = is_ex.fwd.rs1_ex ? wb.data : is_ex.a_data;
  assign op_b  = is_ex.fwd.rs2_ex ? wb.data : is_ex.b_data;
  assign shamt = op_b[shamt_w-1:0];  // SRAI flag sits above these bits

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------
  always_comb begin
    case (is_ex.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = data_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   result = data_t'(op_a < op_b);
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = data_t'($signed(op_a) >>> shamt);  // Sign fill
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;                               // LUI
      default:    result = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // EX/WB register driving the writeback bus
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    wb.rd   <= is_ex.rd;
    wb.data <= result;
    wb.pc   <= is_ex.pc;
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= is_ex.valid && is_ex.we;  // Strobe for real writes only
    end
  end

  // x0 writes are dropped back in decode
  a_no_rd0 : assert property (@(posedge clk) disable iff (reset)
    wb.valid |-> (wb.rd != '0));

endmodule

// ==== src/core_top.sv ====
// RV32I integer core top

module core_top import core_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // Instruction stream, no back-pressure
  input  logic      ins_valid,
  input  data_t     ins_data,
  // Retiring writes
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output data_t     wb_data,
  output data_t     wb_pc
);

  logic   if_valid;
  instr_t if_instr;
  data_t  if_pc;
  id_is_t id_is;
  is_ex_t is_ex;

  wb_bus_if wb_bus ();  // Result and forwarding bus

  // ----------------------------------------------------------------------
  // Pipeline, one cycle per stage
  // ----------------------------------------------------------------------
  fetch_unit i_fetch (
    .clk       (clk),
    .reset     (reset),
    .ins_valid (ins_valid),
    .ins_data  (ins_data),
    .if_valid  (if_valid),
    .if_instr  (if_instr),
    .if_pc     (if_pc)
  );

  decode_stage i_decode (
    .clk      (clk),
    .reset    (reset),
    .if_valid (if_valid),
    .if_instr (if_instr),
    .if_pc    (if_pc),
    .wb       (wb_bus.sink),
    .id_is    (id_is),
    .is_ex_rd (is_ex.rd),   // Producer two ahead
    .is_ex_we (is_ex.we)
  );

  issue_stage i_issue (
    .clk   (clk),
    .reset (reset),
    .id_is (id_is),
    .wb    (wb_bus.sink),
    .is_ex (is_ex)
  );

  execute_stage i_execute (
    .clk   (clk),
    .reset (reset),
    .is_ex (is_ex),
    .wb    (wb_bus.source)
  );

  // Bus out to the pins
  assign wb_valid = wb_bus.valid;
  assign wb_rd    = wb_bus.rd;
  assign wb_data  = wb_bus.data;
  assign wb_pc    = wb_bus.pc;

endmodule

// ==== testbench/tb_core.sv ====
// Core pipeline testbench
`include "core_cfg.svh"

module tb_core import core_pkg::*; ();

  localparam int    clk_period   = 40;
  localparam int    reset_cycles = 5;
  localparam int    drive_delay  = 5;             // Input skew after the rising edge
  localparam int    max_entries  = 64;
  localparam data_t end_mark     = 32'hffff_ffff; // Instruction column ends the trace

  typedef struct {
    reg_addr_t rd;
    data_t     data;
    data_t     pc;
    int        line;   // Trace entry index
  } expect_t;

  logic      clk = 1'b0;
  logic      reset;
  logic      ins_valid;
  data_t     ins_data;
  logic      wb_valid;
  reg_addr_t wb_rd;
  data_t     wb_data;
  data_t     wb_pc;

  data_t       trace_mem [3*max_entries];  // Three words per instruction
  int          n_instr = 0;
  logic        trace_loaded = 1'b0;
  expect_t     exp_q [$];                  // Results still to retire
  data_t       pc_model;
  logic [31:0] lfsr;
  int          errors = 0;
  int          tests = 0;
  int          tests_failed = 0;
  logic        strobe_seen = 1'b0;
  int          quiet_left = 0;             // Cycles wb_valid must stay low
  int          quiet_errors = 0;

  core_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .ins_valid (ins_valid),
    .ins_data  (ins_data),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .wb_pc     (wb_pc)
  );

  always #(clk_period/2) clk = ~clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0..3 idle cycles, one LFSR step per bit
  task automatic pick_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = gap | (int'(lfsr[0]) << b);
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is x%0d, expected x%0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_data(input string what, input data_t got, input data_t want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic load_trace();
    $readmemh("testbench/core_trace.txt", trace_mem);
    n_instr = 0;
    while (n_instr < max_entries && trace_mem[3*n_instr] != end_mark) begin
      n_instr++;
    end
    if (n_instr == 0 || n_instr == max_entries) begin
      $display("Trace file is empty or has no end marker");
      errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    int      gap;
    instr_t  w;
    expect_t e;
    reset     = 1'b1;
    ins_valid = 1'b0;
    ins_data  = '0;
    lfsr      = 32'hcb1a34fa;
    pc_model  = '0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    reset = 1'b0;
    for (int i = 0; i < n_instr; i++) begin
      pick_gap(gap);
      repeat (gap) begin
        @(posedge clk);
        #(drive_delay);
        ins_valid = 1'b0;                 // Bubble
      end
      @(posedge clk);
      #(drive_delay);
      w         = trace_mem[3*i];
      ins_valid = 1'b1;
      ins_data  = w;
      // AUIPC value in the trace must match this PC
      if (w.u.opcode == `CORE_OP_AUIPC) begin
        check_data("trace AUIPC value", trace_mem[3*i+2], pc_model + {w.u.imm20, 12'b0});
      end
      if (trace_mem[3*i+1] != '0) begin    // rd 0 means no writeback
        e.rd   = reg_addr_t'(trace_mem[3*i+1]);
        e.data = trace_mem[3*i+2];
        e.pc   = pc_model;
        e.line = i;
        exp_q.push_back(e);
      end
      pc_model = pc_model + data_t'(`CORE_PC_STEP);
    end
    @(posedge clk);
    #(drive_delay);
    ins_valid = 1'b0;
    repeat (6) @(posedge clk);            // Four-cycle latency plus margin
    tests++;
    if (exp_q.size() != 0) begin
      $display("Missing writebacks: %0d expected results never appeared", exp_q.size());
      errors++;
      tests_failed++;
      $display("test drain: FAIL");
    end else begin
      $display("test drain: ok");
    end
    $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
             tests, tests - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // ----------------------------------------------------------------------
  // Writeback monitor, samples mid-cycle
  // ----------------------------------------------------------------------
  always @(negedge clk) begin : monitor
    expect_t e;
    int      err0;
    if (reset) begin
      if (wb_valid) begin
        $display("CHECK FAILED at %0t: wb_valid high during reset", $time);
        errors++;
        quiet_errors++;
      end
    end else begin
      if (ins_valid && !strobe_seen) begin
        strobe_seen = 1'b1;
        quiet_left  = 4;                  // Strobe cycle and three more
      end
      if (!strobe_seen || quiet_left > 0) begin
        if (wb_valid) begin
          $display("CHECK FAILED at %0t: wb_valid high before a result is due", $time);
          errors++;
          quiet_errors++;
        end
        if (quiet_left > 0) begin
          quiet_left--;
          if (quiet_left == 0) begin
            tests++;
            if (quiet_errors != 0) tests_failed++;
            $display("test quiet start: %s", (quiet_errors == 0) ? "ok" : "FAIL");
          end
        end
      end else if (wb_valid) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected writeback at %0t: x%0d written with no result pending",
                   $time, wb_rd);
          errors++;
        end else begin
          e    = exp_q.pop_front();
          err0 = errors;
          check_reg("wb_rd", wb_rd, e.rd);
          check_data("wb_data", wb_data, e.data);
          check_data("wb_pc", wb_pc, e.pc);
          tests++;
          if (errors != err0) tests_failed++;
          $display("test %0d (trace entry %0d, x%0d): %s", tests, e.line, e.rd,
                   (errors == err0) ? "ok" : "FAIL");
        end
      end
    end
  end

  // Watchdog, eight cycles per instruction plus slack
  initial begin
    wait (trace_loaded);
    repeat (n_instr * 8 + 20) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", n_instr * 8 + 20);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+src
src/core_pkg.sv
src/core_ifs.sv
src/fetch_unit.sv
src/register_file.sv
src/decode_stage.sv
src/issue_stage.sv
src/execute_stage.sv
src/core_top.sv
testbench/tb_core.sv

// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= NO ERRORS

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code alone is not enough
run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/core_trace.txt ====
// Columns: instruction word, expected rd (00 = no writeback), expected result
// All hex; instruction ffffffff ends the trace
00500093 01 00000005  // addi x1, x0, 5
ffd00113 02 fffffffd  // addi x2, x0, -3
002081b3 03 00000002  // add  x3, x1, x2
40118233 04 fffffffd  // sub  x4, x3, x1
001222b3 05 00000001  // slt  x5, x4, x1
00123333 06 00000000  // sltu x6, x4, x1
005093b3 07 0000000a  // sll  x7, x1, x5
40525433 08 fffffffe  // sra  x8, x4, x5
005254b3 09 7ffffffe  // srl  x9, x4, x5
00944533 0a 80000000  // xor  x10, x8, x9
007565b3 0b 8000000a  // or   x11, x10, x7
0025f633 0c 80000008  // and  x12, x11, x2
123456b7 0d 12345000  // lui  x13, 0x12345
67868693 0d 12345678  // addi x13, x13, 0x678
00001717 0e 00001038  // auipc x14, 0x1 at pc 0x38
fff12793 0f 00000001  // slti x15, x2, -1
fff0b813 10 00000001  // sltiu x16, x1, -1
fff6c893 11 edcba987  // xori x17, x13, -1
4048d913 12 fedcba98  // srai x18, x17, 4
0048d993 13 0edcba98  // srli x19, x17, 4
01c09a13 14 50000000  // slli x20, x1, 28
0ffa6a93 15 500000ff  // ori  x21, x20, 0xff
0f0afb13 16 000000f0  // andi x22, x21, 0xf0
00708013 00 00000000  // addi x0, x1, 7
000000ff 00 00000000  // undefined opcode, rd field x1
400b0c33 18 000000f0  // sub  x24, x22, x0
00000cb3 19 00000000  // add  x25, x0, x0
00008bb3 17 00000005  // add  x23, x1, x0
fffffd17 1a fffff070  // auipc x26, 0xfffff at pc 0x70
80000db7 1b 80000000  // lui  x27, 0x80000
01adae33 1c 00000001  // slt  x28, x27, x26
01bd3eb3 1d 00000000  // sltu x29, x26, x27
ffffffff 00 00000000  // end of trace
